// File: run.sh
#!/bin/sh
# Build the CD system testbench with Verilator, run it and look for the pass line
verilator --binary --timing --assert -Wno-fatal --top-module tb_cd_sys -f src.f \
	&& ./obj_dir/Vtb_cd_sys | tee /dev/stderr | grep -q "Everything OK" \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }

// File: src.f
src/cd_regs_pkg.sv
src/cd_dma_pkg.sv
src/cd_reg_decode.sv
src/dma_engine.sv
src/upload_router.sv
src/cd_sys_top.sv
tests/cd_sys_sva.sv
tests/tb_cd_sys.sv

// File: src/cd_dma_pkg.sv
// DMA engine types: transfer modes, FSM states, configuration and memory request
package cd_dma_pkg;

	// ====================
	// Modes and states

	typedef enum logic [1:0] {
		DMA_COPY_WORD = 2'd0,   // A to B, one word per iteration
		DMA_COPY_BYTE = 2'd1,   // A to B, swapped word then original word
		DMA_FILL      = 2'd2    // Upper half of the value at A
	} dma_mode_e;

	typedef enum logic [2:0] {
		ST_IDLE    = 3'd0,
		ST_START   = 3'd1,   // Base state of the loop
		ST_RD      = 3'd2,
		ST_RD_WAIT = 3'd3,
		ST_RD_DONE = 3'd4,
		ST_WR      = 3'd5,
		ST_WR_DONE = 3'd6,
		ST_DONE    = 3'd7    // End of one iteration
	} dma_state_e;

	// ====================
	// Bundles

	// Count travels beside this struct, its width is a module parameter
	typedef struct packed {
		logic [23:0] addr_a;
		logic [23:0] addr_b;
		logic [31:0] value;
		dma_mode_e   mode;
	} dma_cfg_t;

	typedef struct packed {
		logic        rd;
		logic        wr;
		logic [23:0] addr;    // Byte address, always even
		logic [15:0] wdata;
	} mem_req_t;

endpackage

// File: src/cd_reg_decode.sv
// CD register decoder: loads DMA and upload registers from CPU writes, issues DMA start
`timescale 1ns/1ps

module cd_reg_decode #(
	parameter int COUNT_W = 24   // 17 to 32, high half comes from the high count word
) (
	input  logic                   clk_sys,
	input  logic                   nRESET,
	input  cd_regs_pkg::cpu_wr_t   cpu_wr,
	output cd_dma_pkg::dma_cfg_t   dma_cfg,
	output logic [COUNT_W-1:0]     dma_count,
	output logic                   dma_start,
	output cd_regs_pkg::area_e     area_sel,
	output cd_regs_pkg::area_flags_t map
);

	logic [11:0] offset;
	logic        page_wr;
	logic        word_wr;      // Both strobes low
	logic        low_wr;       // Lower byte strobe low
	logic        start_wr;
	logic        mc_known;
	cd_dma_pkg::dma_mode_e mc_mode;

	logic [23:0] addr_a;
	logic [23:0] addr_b;
	logic [31:0] value;
	logic [15:0] micro0;
	cd_dma_pkg::dma_mode_e mode;

	// ====================
	// Write decode

	assign offset   = {cpu_wr.addr[11:1], 1'b0};
	assign page_wr  = cpu_wr.stb && (cpu_wr.addr[23:12] == cd_regs_pkg::CD_PAGE);
	assign word_wr  = page_wr && !cpu_wr.n_uds && !cpu_wr.n_lds;
	assign low_wr   = page_wr && !cpu_wr.n_lds;
	assign start_wr = page_wr && cpu_wr.n_uds && !cpu_wr.n_lds &&
		(offset == cd_regs_pkg::REG_DMA_START) && cpu_wr.data[6];

	// Mode from the first microcode word
	always_comb
	begin
		mc_known = 1'b1;
		mc_mode  = cd_dma_pkg::DMA_COPY_WORD;
		case (micro0)
			cd_regs_pkg::MC_COPY_WORD_A, cd_regs_pkg::MC_COPY_WORD_B:
				mc_mode = cd_dma_pkg::DMA_COPY_WORD;
			cd_regs_pkg::MC_COPY_BYTE_A, cd_regs_pkg::MC_COPY_BYTE_B:
				mc_mode = cd_dma_pkg::DMA_COPY_BYTE;
			cd_regs_pkg::MC_FILL_A, cd_regs_pkg::MC_FILL_B:
				mc_mode = cd_dma_pkg::DMA_FILL;
			default:
				mc_known = 1'b0;   // Test mode microcode, start is dropped
		endcase
	end

	// ====================
	// Control registers

	always_ff @(posedge clk_sys or negedge nRESET)
	begin
		if (!nRESET)
		begin
			dma_start <= 1'b0;
			area_sel  <= cd_regs_pkg::AREA_SPR;
			map       <= '0;
		end
		else
		begin
			dma_start <= start_wr && mc_known;   // Single cycle pulse
			if (low_wr)
			begin
				case (offset)
					cd_regs_pkg::REG_AREA_SEL:  area_sel <= cd_regs_pkg::area_e'(cpu_wr.data[2:0]);
					cd_regs_pkg::REG_MAP_SPR:   map.spr <= 1'b1;
					cd_regs_pkg::REG_MAP_PCM:   map.pcm <= 1'b1;
					cd_regs_pkg::REG_MAP_Z80:   map.z80 <= 1'b1;
					cd_regs_pkg::REG_MAP_FIX:   map.fix <= 1'b1;
					cd_regs_pkg::REG_UNMAP_SPR: map.spr <= 1'b0;
					cd_regs_pkg::REG_UNMAP_PCM: map.pcm <= 1'b0;
					cd_regs_pkg::REG_UNMAP_Z80: map.z80 <= 1'b0;
					cd_regs_pkg::REG_UNMAP_FIX: map.fix <= 1'b0;
					default: ;
				endcase
			end
		end
	end

	// DMA parameters, split into high and low words
	always_ff @(posedge clk_sys)
	begin
		if (word_wr)
		begin
			case (offset)
				cd_regs_pkg::REG_ADDR_A_HI: addr_a[23:16] <= cpu_wr.data[7:0];
				cd_regs_pkg::REG_ADDR_A_LO: addr_a[15:0]  <= cpu_wr.data;
				cd_regs_pkg::REG_ADDR_B_HI: addr_b[23:16] <= cpu_wr.data[7:0];
				cd_regs_pkg::REG_ADDR_B_LO: addr_b[15:0]  <= cpu_wr.data;
				cd_regs_pkg::REG_VALUE_HI:  value[31:16]  <= cpu_wr.data;
				cd_regs_pkg::REG_VALUE_LO:  value[15:0]   <= cpu_wr.data;
				cd_regs_pkg::REG_COUNT_HI:  dma_count[COUNT_W-1:16] <= cpu_wr.data[COUNT_W-17:0];
				cd_regs_pkg::REG_COUNT_LO:  dma_count[15:0] <= cpu_wr.data;
				cd_regs_pkg::REG_MICRO0:    micro0 <= cpu_wr.data;
				default: ;
			endcase
		end
		if (start_wr && mc_known)
			mode <= mc_mode;
	end

	assign dma_cfg = '{addr_a: addr_a, addr_b: addr_b, value: value, mode: mode};

endmodule

// File: src/cd_regs_pkg.sv
// CD system register map, DMA microcode words, upload areas and the CPU write bus
package cd_regs_pkg;

	// ====================
	// Register offsets inside the FF0 page

	localparam logic [11:0] REG_DMA_START = 12'h060;   // Odd byte, bit 6 starts a transfer
	localparam logic [11:0] REG_ADDR_A_HI = 12'h064;
	localparam logic [11:0] REG_ADDR_A_LO = 12'h066;
	localparam logic [11:0] REG_ADDR_B_HI = 12'h068;
	localparam logic [11:0] REG_ADDR_B_LO = 12'h06A;
	localparam logic [11:0] REG_VALUE_HI  = 12'h06C;
	localparam logic [11:0] REG_VALUE_LO  = 12'h06E;
	localparam logic [11:0] REG_COUNT_HI  = 12'h070;
	localparam logic [11:0] REG_COUNT_LO  = 12'h072;
	localparam logic [11:0] REG_MICRO0    = 12'h07E;
	localparam logic [11:0] REG_AREA_SEL  = 12'h104;
	localparam logic [11:0] REG_MAP_SPR   = 12'h120;
	localparam logic [11:0] REG_MAP_PCM   = 12'h122;
	localparam logic [11:0] REG_MAP_Z80   = 12'h126;
	localparam logic [11:0] REG_MAP_FIX   = 12'h128;
	localparam logic [11:0] REG_UNMAP_SPR = 12'h140;
	localparam logic [11:0] REG_UNMAP_PCM = 12'h142;
	localparam logic [11:0] REG_UNMAP_Z80 = 12'h146;
	localparam logic [11:0] REG_UNMAP_FIX = 12'h148;

	// ====================
	// First microcode words, two per mode

	localparam logic [15:0] MC_COPY_WORD_A = 16'hFE6D;
	localparam logic [15:0] MC_COPY_WORD_B = 16'hFE3D;
	localparam logic [15:0] MC_COPY_BYTE_A = 16'hF2DD;
	localparam logic [15:0] MC_COPY_BYTE_B = 16'hE2DD;
	localparam logic [15:0] MC_FILL_A      = 16'hFFCD;
	localparam logic [15:0] MC_FILL_B      = 16'hFFDD;

	localparam logic [11:0] CD_PAGE     = 12'hFF0;   // Address bits 23 to 12
	localparam logic [3:0]  UPLOAD_ZONE = 4'hE;      // Address bits 23 to 20

	// Upload area codes as written to the area select register
	typedef enum logic [2:0] {
		AREA_SPR = 3'd0,
		AREA_PCM = 3'd1,
		AREA_Z80 = 3'd4,
		AREA_FIX = 3'd5
	} area_e;

	typedef struct packed {
		logic        stb;         // One cycle per write
		logic [23:1] addr;        // Word address
		logic        n_uds;       // Upper data strobe, active low
		logic        n_lds;       // Lower data strobe, active low
		logic [15:0] data;
	} cpu_wr_t;

	typedef struct packed {
		logic spr;
		logic pcm;
		logic z80;
		logic fix;
	} area_flags_t;

endpackage

// File: src/cd_sys_top.sv
// CD system top: register decode, DMA engine and upload router
`timescale 1ns/1ps

module cd_sys_top #(
	parameter int COUNT_W = 24
) (
	input  logic                      clk_sys,
	input  logic                      nRESET,
	input  cd_regs_pkg::cpu_wr_t      cpu_wr,
	input  logic [15:0]               mem_rdata,
	input  logic                      mem_busy,
	output cd_dma_pkg::mem_req_t      mem_req,
	output logic                      dma_running,
	output cd_regs_pkg::area_flags_t  area_wr,
	output logic [15:0]               tr_wr_data,
	output logic [19:1]               tr_wr_addr
);

	cd_dma_pkg::dma_cfg_t      dma_cfg;
	logic [COUNT_W-1:0]        dma_count;
	logic                      dma_start;
	cd_regs_pkg::area_e        area_sel;
	cd_regs_pkg::area_flags_t  map;

	cd_reg_decode #(
		.COUNT_W(COUNT_W)
	) i_cd_reg_decode (
		.clk_sys   (clk_sys),
		.nRESET    (nRESET),
		.cpu_wr    (cpu_wr),
		.dma_cfg   (dma_cfg),
		.dma_count (dma_count),
		.dma_start (dma_start),
		.area_sel  (area_sel),
		.map       (map)
	);

	dma_engine #(
		.COUNT_W(COUNT_W)
	) i_dma_engine (
		.clk_sys     (clk_sys),
		.nRESET      (nRESET),
		.dma_start   (dma_start),
		.dma_cfg     (dma_cfg),
		.dma_count   (dma_count),
		.mem_rdata   (mem_rdata),
		.mem_busy    (mem_busy),
		.mem_req     (mem_req),
		.dma_running (dma_running)
	);

	upload_router i_upload_router (
		.clk_sys     (clk_sys),
		.nRESET      (nRESET),
		.cpu_wr      (cpu_wr),
		.mem_req     (mem_req),
		.dma_running (dma_running),
		.area_sel    (area_sel),
		.map         (map),
		.area_wr     (area_wr),
		.tr_wr_data  (tr_wr_data),
		.tr_wr_addr  (tr_wr_addr)
	);

endmodule

// File: src/dma_engine.sv
// DMA engine: word copy, byte copy and word fill over a busy-gated memory port
`timescale 1ns/1ps

module dma_engine #(
	parameter int COUNT_W = 24
) (
	input  logic                  clk_sys,
	input  logic                  nRESET,
	input  logic                  dma_start,
	input  cd_dma_pkg::dma_cfg_t  dma_cfg,
	input  logic [COUNT_W-1:0]    dma_count,
	input  logic [15:0]           mem_rdata,
	input  logic                  mem_busy,
	output cd_dma_pkg::mem_req_t  mem_req,
	output logic                  dma_running
);

	cd_dma_pkg::dma_state_e state;
	cd_dma_pkg::dma_state_e state_nx;
	cd_dma_pkg::dma_mode_e  run_mode;   // Held for the whole transfer

	logic [COUNT_W-1:0] count_run;
	logic [1:0]         io_cnt;       // Accesses done in this iteration
	logic               rd;
	logic               wr;
	logic [23:0]        rd_addr;
	logic [23:0]        wr_addr;
	logic [15:0]        rd_data;
	logic [15:0]        wdata;

	logic start_go;
	logic rd_ack;
	logic wr_ack;
	logic ld_word;
	logic ld_swap;

	assign start_go = (state == cd_dma_pkg::ST_IDLE) && dma_start;
	assign rd_ack   = (state == cd_dma_pkg::ST_RD_WAIT) && !mem_busy;
	assign wr_ack   = (state == cd_dma_pkg::ST_WR_DONE) && !mem_busy;

	// ====================
	// Next state

	always_comb
	begin
		state_nx = state;
		ld_word  = 1'b0;
		ld_swap  = 1'b0;
		case (state)
			cd_dma_pkg::ST_IDLE:
				if (dma_start)
					state_nx = cd_dma_pkg::ST_START;
			cd_dma_pkg::ST_START:
			begin
				if (count_run == '0)
					state_nx = cd_dma_pkg::ST_IDLE;   // Transfer finished
				else
				begin
					state_nx = cd_dma_pkg::ST_DONE;
					case (run_mode)
						cd_dma_pkg::DMA_COPY_WORD:
						begin
							if (io_cnt == 2'd0)
								state_nx = cd_dma_pkg::ST_RD;
							else if (io_cnt == 2'd1)
							begin
								ld_word  = 1'b1;
								state_nx = cd_dma_pkg::ST_WR;
							end
						end
						cd_dma_pkg::DMA_COPY_BYTE:
						begin
							if (io_cnt == 2'd0)
								state_nx = cd_dma_pkg::ST_RD;
							else if (io_cnt == 2'd1)
							begin
								ld_swap  = 1'b1;   // Swapped word goes first
								state_nx = cd_dma_pkg::ST_WR;
							end
							else if (io_cnt == 2'd2)
							begin
								ld_word  = 1'b1;
								state_nx = cd_dma_pkg::ST_WR;
							end
						end
						cd_dma_pkg::DMA_FILL:
							if (io_cnt == 2'd0)
								state_nx = cd_dma_pkg::ST_WR;
						default: ;
					endcase
				end
			end
			cd_dma_pkg::ST_RD:      state_nx = cd_dma_pkg::ST_RD_WAIT;
			cd_dma_pkg::ST_RD_WAIT: if (!mem_busy) state_nx = cd_dma_pkg::ST_RD_DONE;
			cd_dma_pkg::ST_RD_DONE: state_nx = cd_dma_pkg::ST_START;
			cd_dma_pkg::ST_WR:      state_nx = cd_dma_pkg::ST_WR_DONE;
			cd_dma_pkg::ST_WR_DONE: if (!mem_busy) state_nx = cd_dma_pkg::ST_START;
			cd_dma_pkg::ST_DONE:    state_nx = cd_dma_pkg::ST_START;
			default:                state_nx = cd_dma_pkg::ST_IDLE;
		endcase
	end

	// ====================
	// Control state

	always_ff @(posedge clk_sys or negedge nRESET)
	begin
		if (!nRESET)
		begin
			state       <= cd_dma_pkg::ST_IDLE;
			dma_running <= 1'b0;
			rd          <= 1'b0;
			wr          <= 1'b0;
			io_cnt      <= 2'd0;
			count_run   <= '0;
		end
		else
		begin
			state <= state_nx;
			if (start_go)
				dma_running <= 1'b1;
			else if (state == cd_dma_pkg::ST_START && state_nx == cd_dma_pkg::ST_IDLE)
				dma_running <= 1'b0;

			// Requests hold until the memory is not busy
			if (state == cd_dma_pkg::ST_RD)
				rd <= 1'b1;
			else if (rd_ack)
				rd <= 1'b0;
			if (state == cd_dma_pkg::ST_WR)
				wr <= 1'b1;
			else if (wr_ack)
				wr <= 1'b0;

			if (start_go || state == cd_dma_pkg::ST_DONE)
				io_cnt <= 2'd0;
			else if (state == cd_dma_pkg::ST_RD_DONE || wr_ack)
				io_cnt <= io_cnt + 2'd1;

			if (start_go)
				count_run <= dma_count;
			else if (state == cd_dma_pkg::ST_DONE)
				count_run <= count_run - 1'b1;
		end
	end

	// Addresses and data
	always_ff @(posedge clk_sys)
	begin
		if (start_go)
		begin
			run_mode <= dma_cfg.mode;
			rd_addr  <= dma_cfg.addr_a;
			wr_addr  <= (dma_cfg.mode == cd_dma_pkg::DMA_FILL) ? dma_cfg.addr_a : dma_cfg.addr_b;
			wdata    <= dma_cfg.value[31:16];   // Fill word, lower half unused
		end
		if (state == cd_dma_pkg::ST_RD_DONE)
		begin
			rd_data <= mem_rdata;
			rd_addr <= rd_addr + 24'd2;
		end
		if (wr_ack)
			wr_addr <= wr_addr + 24'd2;
		if (ld_word)
			wdata <= rd_data;
		else if (ld_swap)
			wdata <= {rd_data[7:0], rd_data[15:8]};
	end

	assign mem_req = '{rd: rd, wr: wr, addr: rd ? rd_addr : wr_addr, wdata: wdata};

endmodule

// File: src/upload_router.sv
// Upload router: latches CPU upload writes and gates area write strobes by the map flags
`timescale 1ns/1ps

module upload_router (
	input  logic                      clk_sys,
	input  logic                      nRESET,
	input  cd_regs_pkg::cpu_wr_t      cpu_wr,
	input  cd_dma_pkg::mem_req_t      mem_req,
	input  logic                      dma_running,
	input  cd_regs_pkg::area_e        area_sel,
	input  cd_regs_pkg::area_flags_t  map,
	output cd_regs_pkg::area_flags_t  area_wr,
	output logic [15:0]               tr_wr_data,
	output logic [19:1]               tr_wr_addr
);

	cd_regs_pkg::area_flags_t gated;     // Selected area, if mapped
	cd_regs_pkg::area_flags_t cpu_area;
	logic cpu_e_wr;
	logic dma_e_wr;

	always_comb
	begin
		gated.spr = (area_sel == cd_regs_pkg::AREA_SPR) && map.spr;
		gated.pcm = (area_sel == cd_regs_pkg::AREA_PCM) && map.pcm;
		gated.z80 = (area_sel == cd_regs_pkg::AREA_Z80) && map.z80;
		gated.fix = (area_sel == cd_regs_pkg::AREA_FIX) && map.fix;
	end

	assign cpu_e_wr = cpu_wr.stb && !dma_running && !(cpu_wr.n_uds && cpu_wr.n_lds) &&
		(cpu_wr.addr[23:20] == cd_regs_pkg::UPLOAD_ZONE);
	assign dma_e_wr = dma_running && mem_req.wr &&
		(mem_req.addr[23:20] == cd_regs_pkg::UPLOAD_ZONE);

	always_ff @(posedge clk_sys or negedge nRESET)
	begin
		if (!nRESET)
			cpu_area <= '0;
		else
			cpu_area <= cpu_e_wr ? gated : '0;   // One cycle strobe
	end

	always_ff @(posedge clk_sys)
	begin
		if (cpu_e_wr)
		begin
			tr_wr_data <= cpu_wr.data;
			tr_wr_addr <= cpu_wr.addr[19:1];
		end
	end

	// DMA strobes follow the write request directly
	assign area_wr = cpu_area | (dma_e_wr ? gated : '0);

endmodule

// File: tests/cd_sys_sva.sv
// Bound checks on the CD system memory port, area strobes and DMA activity
`timescale 1ns/1ps

module cd_sys_sva (
	input logic                     clk_sys,
	input logic                     nRESET,
	input cd_regs_pkg::cpu_wr_t     cpu_wr,
	input cd_dma_pkg::mem_req_t     mem_req,
	input logic                     mem_busy,
	input logic                     dma_running,
	input cd_regs_pkg::area_flags_t area_wr
);

	logic dma_e_wr;
	logic cpu_e_wr;

	assign dma_e_wr = dma_running && mem_req.wr &&
		(mem_req.addr[23:20] == cd_regs_pkg::UPLOAD_ZONE);
	assign cpu_e_wr = cpu_wr.stb && (cpu_wr.addr[23:20] == cd_regs_pkg::UPLOAD_ZONE);

	rd_wr_exclusive: assert property (@(posedge clk_sys) disable iff (!nRESET)
		!(mem_req.rd && mem_req.wr))
		else $error("Read and write requested together");

	rd_holds: assert property (@(posedge clk_sys) disable iff (!nRESET)
		(mem_req.rd && mem_busy) |=> (mem_req.rd && $stable(mem_req.addr)))
		else $error("Read request dropped or moved while busy");

	wr_holds: assert property (@(posedge clk_sys) disable iff (!nRESET)
		(mem_req.wr && mem_busy) |=> (mem_req.wr && $stable(mem_req.addr) &&
		$stable(mem_req.wdata)))
		else $error("Write request dropped or changed while busy");

	// CPU strobe lags its write by one cycle, DMA strobe is immediate
	area_only_on_e_write: assert property (@(posedge clk_sys) disable iff (!nRESET)
		(area_wr != '0) |-> (dma_e_wr || $past(cpu_e_wr)))
		else $error("Area strobe without an E zone write");

	req_needs_running: assert property (@(posedge clk_sys) disable iff (!nRESET)
		(mem_req.rd || mem_req.wr) |-> dma_running)
		else $error("Memory request outside a running transfer");

endmodule

bind cd_sys_top cd_sys_sva i_cd_sys_sva (
	.clk_sys     (clk_sys),
	.nRESET      (nRESET),
	.cpu_wr      (cpu_wr),
	.mem_req     (mem_req),
	.mem_busy    (mem_busy),
	.dma_running (dma_running),
	.area_wr     (area_wr)
);

// File: tests/tb_cd_sys.sv
// Testbench for the CD system block covering DMA copy and fill modes, upload strobes and area gating
`timescale 1ns/1ps

module tb_cd_sys;

	localparam int COUNT_W         = 24;
	localparam int TOTAL_WORDS     = 8 + 6 + 10 + 4 + 4 + 4;   // Words over all programmed transfers
	localparam int WATCHDOG_CYCLES = 200 * TOTAL_WORDS + 1000;
	localparam cd_regs_pkg::area_flags_t FIX_ONLY = '{spr: 1'b0, pcm: 1'b0, z80: 1'b0, fix: 1'b1};

	logic                      clk_sys = 1'b0;
	logic                      nRESET;
	cd_regs_pkg::cpu_wr_t      cpu_wr;
	logic [15:0]               mem_rdata = '0;
	logic                      mem_busy = 1'b0;
	cd_dma_pkg::mem_req_t      mem_req;
	logic                      dma_running;
	cd_regs_pkg::area_flags_t  area_wr;
	logic [15:0]               tr_wr_data;
	logic [19:1]               tr_wr_addr;

	logic [15:0] mem [0:65535];          // Word memory indexed by address bits 16 to 1
	logic [31:0] lfsr = 32'h978b_b636;
	logic        busy_hi;
	logic [23:0] exp_addr [$];           // Expected writes in order
	logic [15:0] exp_data [$];
	logic        req_allowed;
	cd_regs_pkg::area_flags_t dma_area_exp;
	cd_regs_pkg::area_flags_t last_strobe;
	int          strobe_cycles = 0;
	int          base;

	cd_sys_top #(
		.COUNT_W(COUNT_W)
	) i_cd_sys_top (
		.clk_sys     (clk_sys),
		.nRESET      (nRESET),
		.cpu_wr      (cpu_wr),
		.mem_rdata   (mem_rdata),
		.mem_busy    (mem_busy),
		.mem_req     (mem_req),
		.dma_running (dma_running),
		.area_wr     (area_wr),
		.tr_wr_data  (tr_wr_data),
		.tr_wr_addr  (tr_wr_addr)
	);

	always #2 clk_sys = ~clk_sys;   // 4 ns period

	// ====================
	// Helpers and reference

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [15:0] fill_pattern(input logic [15:0] idx);
		return (idx * 16'h9E37) ^ {idx[3:0], idx[15:4]} ^ 16'h5AC3;
	endfunction

	// Write k of a transfer as {address, data}
	// Sources are never overwritten, so they keep the fill pattern
	function automatic logic [39:0] ref_write(input cd_dma_pkg::dma_mode_e mode,
		input logic [23:0] a, input logic [23:0] b, input logic [31:0] value, input int k);
		logic [23:0] src;
		logic [15:0] word;
		logic [39:0] res;
		src  = a + 24'(2 * (k / 2));
		word = fill_pattern(src[16:1]);
		case (mode)
			cd_dma_pkg::DMA_COPY_WORD:
			begin
				src = a + 24'(2 * k);
				res = {b + 24'(2 * k), fill_pattern(src[16:1])};
			end
			cd_dma_pkg::DMA_COPY_BYTE:
				if (k % 2 == 0)
					res = {b + 24'(4 * (k / 2)), word[7:0], word[15:8]};   // Swapped first
				else
					res = {b + 24'(4 * (k / 2) + 2), word};
			default:
				res = {a + 24'(2 * k), value[31:16]};
		endcase
		return res;
	endfunction

	task automatic abort_run();
		$display("Something failed");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
		assert (got === exp)
		else
		begin
			$display("ERR %s expected %h got %h", name, exp, got);
			abort_run();
		end
	endtask

	task automatic cpu_write(input logic [23:0] byte_addr, input logic [15:0] data,
		input logic n_uds, input logic n_lds);
		@(negedge clk_sys);
		cpu_wr = '{stb: 1'b1, addr: byte_addr[23:1], n_uds: n_uds, n_lds: n_lds, data: data};
		@(negedge clk_sys);
		cpu_wr = '{stb: 1'b0, addr: '0, n_uds: 1'b1, n_lds: 1'b1, data: '0};
	endtask

	task automatic reg_write(input logic [11:0] offset, input logic [15:0] data);
		cpu_write({cd_regs_pkg::CD_PAGE, offset}, data, 1'b0, 1'b0);
	endtask

	task automatic program_dma(input logic [15:0] micro, input logic [23:0] a,
		input logic [23:0] b, input logic [31:0] value, input logic [23:0] count);
		reg_write(cd_regs_pkg::REG_ADDR_A_HI, {8'h00, a[23:16]});
		reg_write(cd_regs_pkg::REG_ADDR_A_LO, a[15:0]);
		reg_write(cd_regs_pkg::REG_ADDR_B_HI, {8'h00, b[23:16]});
		reg_write(cd_regs_pkg::REG_ADDR_B_LO, b[15:0]);
		reg_write(cd_regs_pkg::REG_VALUE_HI, value[31:16]);
		reg_write(cd_regs_pkg::REG_VALUE_LO, value[15:0]);
		reg_write(cd_regs_pkg::REG_COUNT_HI, {8'h00, count[23:16]});
		reg_write(cd_regs_pkg::REG_COUNT_LO, count[15:0]);
		reg_write(cd_regs_pkg::REG_MICRO0, micro);
	endtask

	task automatic start_dma(input logic go);
		cpu_write({cd_regs_pkg::CD_PAGE, cd_regs_pkg::REG_DMA_START}, {9'd0, go, 6'd0}, 1'b1, 1'b0);
	endtask

	task automatic wait_done(input int words);
		int cycles;
		cycles = 0;
		while (!dma_running && cycles < 10)
		begin
			@(negedge clk_sys);
			cycles++;
		end
		assert (dma_running)
		else
		begin
			$display("DMA did not start after the start write");
			abort_run();
		end
		cycles = 0;
		while (dma_running && cycles < 200 * words)
		begin
			@(negedge clk_sys);
			cycles++;
		end
		assert (!dma_running)
		else
		begin
			$display("DMA did not finish within %0d cycles", 200 * words);
			abort_run();
		end
	endtask

	task automatic expect_no_start();
		repeat (50)
		begin
			@(negedge clk_sys);
			assert (!dma_running)
			else
			begin
				$display("DMA started although the start write was invalid");
				abort_run();
			end
		end
	endtask

	task automatic run_transfer(input cd_dma_pkg::dma_mode_e mode, input logic [15:0] micro,
		input logic [23:0] a, input logic [23:0] b, input logic [31:0] value, input int n);
		int nwr;
		logic [39:0] w;
		nwr = (mode == cd_dma_pkg::DMA_COPY_BYTE) ? 2 * n : n;
		program_dma(micro, a, b, value, 24'(n));
		for (int k = 0; k < nwr; k++)
		begin
			w = ref_write(mode, a, b, value, k);
			exp_addr.push_back(w[39:16]);
			exp_data.push_back(w[15:0]);
		end
		req_allowed = 1'b1;
		start_dma(1'b1);
		wait_done(n);
		req_allowed = 1'b0;
		assert (exp_addr.size() == 0)
		else
		begin
			$display("Transfer ended with %0d writes missing", exp_addr.size());
			abort_run();
		end
		// Final memory contents
		for (int k = 0; k < nwr; k++)
		begin
			w = ref_write(mode, a, b, value, k);
			check_value($sformatf("mem[%h]", w[39:16]), 32'(w[15:0]), 32'(mem[w[32:17]]));
		end
	endtask

	// ====================
	// Memory model and compare process

	always @(negedge clk_sys)
	begin
		if (nRESET)
		begin
			lfsr     = lfsr_next(lfsr);
			busy_hi  = lfsr[0];
			lfsr     = lfsr_next(lfsr);
			mem_busy = busy_hi && lfsr[0];   // Busy about one cycle in four
			if (mem_req.rd && !mem_busy)
				mem_rdata = mem[mem_req.addr[16:1]];   // Data for the edge that takes the read
		end
	end

	always @(posedge clk_sys)
	begin
		if (!nRESET)
		begin
			for (int i = 0; i < 65536; i++)
				mem[i] <= fill_pattern(16'(i));
		end
		else
		begin
			if (mem_req.wr && !mem_busy)
				mem[mem_req.addr[16:1]] <= mem_req.wdata;
		end
	end

	always @(posedge clk_sys)
	begin : compare_proc
		cd_regs_pkg::area_flags_t area_exp;
		if (nRESET)
		begin
			assert (req_allowed || !(mem_req.rd || mem_req.wr))
			else
			begin
				$display("Memory request seen while no transfer was started");
				abort_run();
			end
			if (mem_req.wr && !mem_busy)
			begin
				assert (exp_addr.size() != 0)
				else
				begin
					$display("More memory writes than the transfer should make");
					abort_run();
				end
				if (exp_addr.size() != 0)
				begin
					check_value("mem_req.addr", 32'(exp_addr.pop_front()), 32'(mem_req.addr));
					check_value("mem_req.wdata", 32'(exp_data.pop_front()), 32'(mem_req.wdata));
				end
			end
			if (dma_running)
			begin
				area_exp = (mem_req.wr && mem_req.addr[23:20] == 4'hE) ? dma_area_exp : '0;
				check_value("area_wr", 32'(area_exp), 32'(area_wr));
			end
			if (area_wr != '0)
			begin
				strobe_cycles++;
				last_strobe = area_wr;
			end
		end
	end

	// ====================
	// Tests

	initial
	begin
		cpu_wr       = '{stb: 1'b0, addr: '0, n_uds: 1'b1, n_lds: 1'b1, data: '0};
		nRESET       = 1'b0;
		req_allowed  = 1'b0;
		dma_area_exp = '0;
		repeat (8) @(posedge clk_sys);
		@(negedge clk_sys);
		nRESET = 1'b1;

		run_transfer(cd_dma_pkg::DMA_COPY_WORD, cd_regs_pkg::MC_COPY_WORD_A,
			24'h00_2000, 24'h00_4000, 32'h0, 8);
		run_transfer(cd_dma_pkg::DMA_COPY_BYTE, cd_regs_pkg::MC_COPY_BYTE_B,
			24'h00_2100, 24'h00_5000, 32'h0, 6);
		run_transfer(cd_dma_pkg::DMA_FILL, cd_regs_pkg::MC_FILL_A,
			24'h00_6000, 24'h00_7000, 32'hC0DE_1234, 10);

		// Unknown microcode and then a known one with bit 6 clear
		program_dma(16'h1234, 24'h00_2000, 24'h00_7800, 32'h0, 24'd4);
		start_dma(1'b1);
		expect_no_start();
		program_dma(cd_regs_pkg::MC_FILL_B, 24'h00_7800, 24'h00_7800, 32'h0, 24'd4);
		start_dma(1'b0);
		expect_no_start();

		// CPU upload write with fix selected and pcm mapped but not selected
		reg_write(cd_regs_pkg::REG_AREA_SEL, 16'd5);
		reg_write(cd_regs_pkg::REG_MAP_PCM, 16'h0000);
		reg_write(cd_regs_pkg::REG_MAP_FIX, 16'h0000);
		base = strobe_cycles;
		cpu_write(24'hE1_2346, 16'hBEEF, 1'b0, 1'b0);
		repeat (3) @(negedge clk_sys);
		check_value("area_wr pulse count", 32'd1, 32'(strobe_cycles - base));
		check_value("area_wr", 32'(FIX_ONLY), 32'(last_strobe));
		check_value("tr_wr_data", 32'hBEEF, 32'(tr_wr_data));
		check_value("tr_wr_addr", 32'(19'h0_91A3), 32'(tr_wr_addr));   // E12346 bits 19 to 1
		reg_write(cd_regs_pkg::REG_UNMAP_FIX, 16'h0000);
		base = strobe_cycles;
		cpu_write(24'hE1_2346, 16'hBEEF, 1'b0, 1'b0);
		repeat (3) @(negedge clk_sys);
		check_value("area_wr pulse count", 32'd0, 32'(strobe_cycles - base));

		// DMA into the E zone with fix mapped again
		reg_write(cd_regs_pkg::REG_MAP_FIX, 16'h0000);
		dma_area_exp = FIX_ONLY;
		base = strobe_cycles;
		run_transfer(cd_dma_pkg::DMA_COPY_WORD, cd_regs_pkg::MC_COPY_WORD_B,
			24'h00_2200, 24'hE0_8000, 32'h0, 4);
		dma_area_exp = '0;
		assert (strobe_cycles - base >= 4)
		else
		begin
			$display("Too few fix strobes during the E zone transfer");
			abort_run();
		end

		$display("Everything OK");
		$finish;
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("Watchdog expired before the tests completed");
		abort_run();
	end

endmodule
